/* hdl/axi_rd_pkg.sv */
// *************************************************************************
// AXI read bridge types and constants
// *************************************************************************

package axi_rd_pkg;

	// Bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int ID_W   = 4;

	// Tag slots, also the number of credits the splitter starts with
	localparam int TAG_DEPTH = 4;
	localparam int CREDIT_W  = 3;

	// AXI burst codes
	localparam logic [1:0] BURST_FIXED = 2'b00;
	localparam logic [1:0] BURST_INCR  = 2'b01;
	localparam logic [1:0] BURST_WRAP  = 2'b10;

	// AXI response codes
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	typedef struct packed {
		logic [ID_W-1:0]   id;
		logic [ADDR_W-1:0] addr;
		logic [7:0]        len;
		logic [2:0]        size;
		logic [1:0]        burst;
	} axi_ar_t;

	typedef struct packed {
		logic [ID_W-1:0]   id;
		logic [DATA_W-1:0] data;
		logic [1:0]        resp;
		logic              last;
	} axi_r_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
	} mem_req_t;

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic              err;
	} mem_rsp_t;

	// Per-beat bookkeeping carried from splitter to merger
	typedef struct packed {
		logic [ID_W-1:0] id;
		logic            last;
	} rd_tag_t;

endpackage

/* hdl/burst_splitter.sv */
// *************************************************************************
// AXI read burst splitter
// *************************************************************************

`timescale 1ns/1ps

module burst_splitter (
	input  logic                 clk,
	input  logic                 rst_n,
	input  axi_rd_pkg::axi_ar_t  ar,
	input  logic                 ar_valid,
	output logic                 ar_ready,
	output axi_rd_pkg::mem_req_t mem_req,
	output logic                 mem_req_valid,
	input  logic                 mem_req_ready,
	output axi_rd_pkg::rd_tag_t  tag,
	output logic                 tag_push,
	input  logic                 credit_return
);
	import axi_rd_pkg::*;

	logic                busy;
	logic [ID_W-1:0]     cur_id;
	logic [ADDR_W-1:0]   cur_addr;
	logic [7:0]          beats_left;
	logic [2:0]          cur_size;
	logic [1:0]          cur_burst;
	logic [CREDIT_W-1:0] credits;
	logic                ar_fire;
	logic                issue;
	logic                last_beat;
	logic [ADDR_W-1:0]   addr_step;
	logic [ADDR_W-1:0]   addr_next;

	// *********************************************************************
	// Handshakes
	// *********************************************************************

	assign ar_ready      = !busy;
	assign ar_fire       = ar_valid && ar_ready;
	assign mem_req_valid = busy && (credits != '0);
	assign issue         = mem_req_valid && mem_req_ready;
	assign tag_push      = issue;

	// Zero beats left means the beat on the bus closes the burst
	assign last_beat = (beats_left == 8'd0);

	assign mem_req = '{addr: cur_addr};
	assign tag     = '{id: cur_id, last: last_beat};

	// *********************************************************************
	// Address sequencing
	// *********************************************************************

	assign addr_step = ADDR_W'(1) << cur_size;

	always_comb begin
		case (cur_burst)
			// WRAP has no boundary logic here and steps like INCR
			BURST_INCR, BURST_WRAP: addr_next = cur_addr + addr_step;
			BURST_FIXED:            addr_next = cur_addr;
			default:                addr_next = cur_addr;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
		end else if (ar_fire) begin
			busy <= 1'b1;
		end else if (issue && last_beat) begin
			busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (ar_fire) begin
			cur_id     <= ar.id;
			cur_addr   <= ar.addr;
			beats_left <= ar.len;
			cur_size   <= ar.size;
			cur_burst  <= ar.burst;
		end else if (issue) begin
			cur_addr   <= addr_next;
			beats_left <= beats_left - 8'd1;
		end
	end

	// One credit per free tag slot
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			credits <= CREDIT_W'(TAG_DEPTH);
		end else begin
			case ({issue, credit_return})
				2'b10:   credits <= credits - CREDIT_W'(1);
				2'b01:   credits <= credits + CREDIT_W'(1);
				default: credits <= credits;
			endcase
		end
	end

endmodule

/* hdl/tag_fifo.sv */
// *************************************************************************
// Read tag FIFO
// *************************************************************************

`timescale 1ns/1ps

module tag_fifo (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                push,
	input  axi_rd_pkg::rd_tag_t din,
	input  logic                pop,
	output axi_rd_pkg::rd_tag_t head,
	output logic                head_valid,
	output logic                credit_return
);
	import axi_rd_pkg::*;

	localparam int PTR_W = $clog2(TAG_DEPTH);

	rd_tag_t             slots [TAG_DEPTH];
	logic [PTR_W-1:0]    wr_ptr;
	logic [PTR_W-1:0]    rd_ptr;
	logic [CREDIT_W-1:0] count;
	logic                pop_ok;

	assign head_valid    = (count != '0);
	assign head          = slots[rd_ptr];
	assign pop_ok        = pop && head_valid;
	assign credit_return = pop_ok;

	// Tag storage
	always_ff @(posedge clk) begin
		if (push) begin
			slots[wr_ptr] <= din;
		end
	end

	// Pointers wrap at the last slot so any depth works
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(TAG_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
			end
			if (pop_ok) begin
				rd_ptr <= (rd_ptr == PTR_W'(TAG_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
			end
		end
	end

	// Occupancy, never beyond TAG_DEPTH while the splitter honours its credits
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count <= '0;
		end else begin
			case ({push, pop_ok})
				2'b10:   count <= count + CREDIT_W'(1);
				2'b01:   count <= count - CREDIT_W'(1);
				default: count <= count;
			endcase
		end
	end

endmodule

/* hdl/read_resp_merger.sv */
// *************************************************************************
// Read response merger
// *************************************************************************

`timescale 1ns/1ps

module read_resp_merger (
	input  logic                 clk,
	input  logic                 rst_n,
	input  axi_rd_pkg::mem_rsp_t mem_rsp,
	input  logic                 mem_rsp_valid,
	output logic                 mem_rsp_ready,
	input  axi_rd_pkg::rd_tag_t  head,
	input  logic                 head_valid,
	output logic                 pop,
	output axi_rd_pkg::axi_r_t   r,
	output logic                 r_valid,
	input  logic                 r_ready
);
	import axi_rd_pkg::*;

	logic       can_load;
	logic       accept;
	logic [1:0] resp_code;

	// Output register is free when empty or being drained this cycle
	assign can_load      = !r_valid || r_ready;
	assign mem_rsp_ready = head_valid && can_load;
	assign accept        = mem_rsp_valid && mem_rsp_ready;
	assign pop           = accept;

	assign resp_code = mem_rsp.err ? RESP_SLVERR : RESP_OKAY;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			r_valid <= 1'b0;
		end else if (accept) begin
			r_valid <= 1'b1;
		end else if (r_ready) begin
			r_valid <= 1'b0;
		end
	end

	// Beat payload, held while the master stalls
	always_ff @(posedge clk) begin
		if (accept) begin
			r <= '{id: head.id, data: mem_rsp.data, resp: resp_code, last: head.last};
		end
	end

endmodule

/* hdl/axi_rd_bridge.sv */
// *************************************************************************
// AXI read to memory bridge
// *************************************************************************

`timescale 1ns/1ps

module axi_rd_bridge (
	input  logic                 clk,
	input  logic                 rst_n,
	// AXI read address
	input  axi_rd_pkg::axi_ar_t  ar,
	input  logic                 ar_valid,
	output logic                 ar_ready,
	// AXI read data
	output axi_rd_pkg::axi_r_t   r,
	output logic                 r_valid,
	input  logic                 r_ready,
	// Memory side
	output axi_rd_pkg::mem_req_t mem_req,
	output logic                 mem_req_valid,
	input  logic                 mem_req_ready,
	input  axi_rd_pkg::mem_rsp_t mem_rsp,
	input  logic                 mem_rsp_valid,
	output logic                 mem_rsp_ready
);
	import axi_rd_pkg::*;

	rd_tag_t tag;
	logic    tag_push;
	rd_tag_t head;
	logic    head_valid;
	logic    pop;
	logic    credit_return;

	// *********************************************************************
	// Request side
	// *********************************************************************

	burst_splitter i_splitter (
		.clk           (clk),
		.rst_n         (rst_n),
		.ar            (ar),
		.ar_valid      (ar_valid),
		.ar_ready      (ar_ready),
		.mem_req       (mem_req),
		.mem_req_valid (mem_req_valid),
		.mem_req_ready (mem_req_ready),
		.tag           (tag),
		.tag_push      (tag_push),
		.credit_return (credit_return)
	);

	tag_fifo i_tag_fifo (
		.clk           (clk),
		.rst_n         (rst_n),
		.push          (tag_push),
		.din           (tag),
		.pop           (pop),
		.head          (head),
		.head_valid    (head_valid),
		.credit_return (credit_return)
	);

	// *********************************************************************
	// Response side
	// *********************************************************************

	read_resp_merger i_merger (
		.clk           (clk),
		.rst_n         (rst_n),
		.mem_rsp       (mem_rsp),
		.mem_rsp_valid (mem_rsp_valid),
		.mem_rsp_ready (mem_rsp_ready),
		.head          (head),
		.head_valid    (head_valid),
		.pop           (pop),
		.r             (r),
		.r_valid       (r_valid),
		.r_ready       (r_ready)
	);

endmodule

/* test/tb_clock.sv */
// *************************************************************************
// Testbench clock and reset
// *************************************************************************

`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic rst_n
);
	localparam int HALF_NS      = 5;
	localparam int RESET_CYCLES = 3;

	initial begin
		clk = 1'b0;
		forever #HALF_NS clk = ~clk;
	end

	// Reset released just after the third rising edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule

/* test/axi_rd_bridge_properties.sv */
// *************************************************************************
// AXI read bridge assertions
// *************************************************************************

`timescale 1ns/1ps

module axi_rd_bridge_properties (
	input logic                clk,
	input logic                rst_n,
	input logic                ar_valid,
	input logic                ar_ready,
	input axi_rd_pkg::axi_r_t  r,
	input logic                r_valid,
	input logic                r_ready,
	input logic                mem_req_valid,
	input axi_rd_pkg::rd_tag_t tag,
	input logic                tag_push,
	input logic                pop,
	input logic                credit_return
);
	import axi_rd_pkg::*;

	logic [CREDIT_W-1:0] fill;
	logic [CREDIT_W-1:0] credits_held;
	logic                in_burst;

	// Shadow counts kept from the handshakes alone
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fill         <= '0;
			credits_held <= CREDIT_W'(TAG_DEPTH);
			in_burst     <= 1'b0;
		end else begin
			fill         <= fill + CREDIT_W'(tag_push) - CREDIT_W'(pop);
			credits_held <= credits_held - CREDIT_W'(tag_push) + CREDIT_W'(credit_return);
			if (ar_valid && ar_ready) begin
				in_burst <= 1'b1;
			end else if (tag_push && tag.last) begin
				in_burst <= 1'b0;
			end
		end
	end

	r_held: assert property (@(posedge clk) disable iff (!rst_n)
		r_valid && !r_ready |=> r_valid && $stable(r))
		else $error("R beat changed or dropped while stalled");

	no_full_push: assert property (@(posedge clk) disable iff (!rst_n)
		fill == CREDIT_W'(TAG_DEPTH) |-> !tag_push)
		else $error("tag pushed into a full tag FIFO");

	credit_gate: assert property (@(posedge clk) disable iff (!rst_n)
		credits_held == '0 |-> !mem_req_valid)
		else $error("memory request issued without a credit");

	ar_closed: assert property (@(posedge clk) disable iff (!rst_n)
		in_burst |-> !ar_ready)
		else $error("ar_ready high during a burst");

endmodule

/* test/tb_axi_rd_bridge.sv */
// *************************************************************************
// AXI read bridge testbench
// *************************************************************************

`timescale 1ns/1ps

module tb_axi_rd_bridge;
	import axi_rd_pkg::*;

	localparam int NUM_TESTS = 8;
	localparam int CLK_NS    = 10;
	localparam int DRIVE_NS  = 1;
	localparam logic [ADDR_W-1:0] DATA_MASK = 32'hA5A5_0000;
	localparam logic [ADDR_W-1:0] ERR_BASE  = 32'h0001_0000;

	typedef struct packed {
		logic [ID_W-1:0]   id;
		logic [ADDR_W-1:0] addr;
		logic [7:0]        len;
		logic [2:0]        size;
		logic [1:0]        burst;
		logic [7:0]        duty;
		logic              chain;
	} test_row_t;

	logic     clk;
	logic     rst_n;
	axi_ar_t  ar;
	logic     ar_valid;
	logic     ar_ready;
	axi_r_t   r;
	logic     r_valid;
	logic     r_ready;
	mem_req_t mem_req;
	logic     mem_req_valid;
	logic     mem_req_ready;
	mem_rsp_t mem_rsp;
	logic     mem_rsp_valid;
	logic     mem_rsp_ready;

	test_row_t         tests [NUM_TESTS];
	logic [ADDR_W-1:0] mem_pending [$];
	axi_r_t            r_seen [$];
	logic [31:0]       lcg_state;
	logic [7:0]        duty;
	int                errors;
	int                checks;
	int                bad_tests;

	tb_clock i_clock (.clk(clk), .rst_n(rst_n));

	axi_rd_bridge i_dut (
		.clk(clk), .rst_n(rst_n),
		.ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
		.r(r), .r_valid(r_valid), .r_ready(r_ready),
		.mem_req(mem_req), .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
		.mem_rsp(mem_rsp), .mem_rsp_valid(mem_rsp_valid), .mem_rsp_ready(mem_rsp_ready)
	);

	bind axi_rd_bridge axi_rd_bridge_properties i_props (
		.clk(clk), .rst_n(rst_n), .ar_valid(ar_valid), .ar_ready(ar_ready),
		.r(r), .r_valid(r_valid), .r_ready(r_ready), .mem_req_valid(mem_req_valid),
		.tag(tag), .tag_push(tag_push), .pop(pop), .credit_return(credit_return)
	);

	// Ready draw with the current test's duty cycle in percent
	function automatic logic draw_ready();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return (lcg_state[23:16] % 8'd100) < duty;
	endfunction

	function automatic logic [ADDR_W-1:0] beat_addr(input test_row_t row, input int beat);
		if (row.burst == BURST_FIXED) begin
			return row.addr;
		end
		return row.addr + (ADDR_W'(beat) << row.size);
	endfunction

	task automatic check_beat(input axi_r_t got, input axi_r_t exp, input int t, input int beat);
		checks++;
		if (got !== exp) begin
			errors++;
			$write("FAILED at %0t: test %0d beat %0d, ", $time, t, beat);
			$display("id %h/%h data %h/%h resp %0d/%0d last %0b/%0b (got/expected)",
				got.id, exp.id, got.data, exp.data, got.resp, exp.resp, got.last, exp.last);
		end
	endtask

	task automatic check_count(input int got, input int exp, input int t);
		checks++;
		if (got != exp) begin
			errors++;
			$display("FAILED at %0t: test %0d returned %0d beats, expected %0d",
				$time, t, got, exp);
		end
	endtask

	task automatic send_burst(input test_row_t row);
		@(posedge clk);
		#DRIVE_NS;
		ar       = '{id: row.id, addr: row.addr, len: row.len, size: row.size, burst: row.burst};
		ar_valid = 1'b1;
		@(negedge clk);
		while (!ar_ready) @(negedge clk);
		@(posedge clk);
		#DRIVE_NS;
		ar_valid = 1'b0;
	endtask

	// Beats of one burst up to and including the first one flagged last
	task automatic check_test(input int t);
		test_row_t         row;
		axi_r_t            got;
		axi_r_t            exp;
		logic [ADDR_W-1:0] addr;
		int                n;
		int                errs_before;
		logic              done;
		row         = tests[t];
		errs_before = errors;
		n           = 0;
		done        = 1'b0;
		while (!done && r_seen.size() != 0) begin
			got  = r_seen.pop_front();
			addr = beat_addr(row, n);
			exp  = '{id: row.id, data: addr ^ DATA_MASK, last: (n == int'(row.len)),
				resp: (addr >= ERR_BASE) ? RESP_SLVERR : RESP_OKAY};
			check_beat(got, exp, t, n);
			n++;
			done = got.last;
		end
		check_count(n, int'(row.len) + 1, t);
		if (errors != errs_before) begin
			bad_tests++;
		end
		$display("test %0d: id %h addr %h beats %0d burst %0d duty %0d: %s", t, row.id,
			row.addr, n, row.burst, row.duty, (errors == errs_before) ? "ok" : "errors");
	endtask

	// ********************************************************************
	// Memory model and R sink
	// ********************************************************************

	initial begin : bus_model
		logic              req_fire;
		logic              rsp_fire;
		logic [ADDR_W-1:0] req_addr;
		mem_req_ready = 1'b0;
		mem_rsp_valid = 1'b0;
		mem_rsp       = '0;
		r_ready       = 1'b0;
		forever begin
			@(negedge clk);
			req_fire = mem_req_valid && mem_req_ready;
			rsp_fire = mem_rsp_valid && mem_rsp_ready;
			req_addr = mem_req.addr;
			if (r_valid && r_ready) begin
				r_seen.push_back(r);
			end
			@(posedge clk);
			#DRIVE_NS;
			if (rsp_fire) begin
				void'(mem_pending.pop_front());
			end
			if (req_fire) begin
				mem_pending.push_back(req_addr);
			end
			// A response not yet taken stays on the bus unchanged
			if (!mem_rsp_valid || rsp_fire) begin
				mem_rsp_valid = (mem_pending.size() != 0) && draw_ready();
				if (mem_rsp_valid) begin
					mem_rsp = '{data: mem_pending[0] ^ DATA_MASK, err: mem_pending[0] >= ERR_BASE};
				end
			end
			mem_req_ready = draw_ready();
			r_ready       = draw_ready();
		end
	end

	initial begin : watchdog
		int total_beats;
		@(posedge rst_n);
		total_beats = 0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			total_beats += int'(tests[t].len) + 1;
		end
		#(total_beats * 50 * CLK_NS);
		$display("ERROR: timeout after %0d cycles, not all R beats came back", total_beats * 50);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin : main_seq
		int group_start;
		int group_beats;
		$timeformat(-9, 0, " ns", 0);
		ar        = '0;
		ar_valid  = 1'b0;
		lcg_state = 32'h2fd9;
		duty      = 8'd100;
		errors    = 0;
		checks    = 0;
		bad_tests = 0;
		// id, addr, len, size, burst, ready duty, chain into next burst
		tests[0] = '{4'h3, 32'h0000_1000, 8'd7, 3'd2, BURST_INCR, 8'd100, 1'b0};
		tests[1] = '{4'h5, 32'h0000_2040, 8'd3, 3'd2, BURST_FIXED, 8'd70, 1'b0};
		tests[2] = '{4'h1, 32'h0000_0300, 8'd0, 3'd2, BURST_INCR, 8'd60, 1'b0};
		tests[3] = '{4'h9, 32'h0000_4000, 8'd15, 3'd2, BURST_INCR, 8'd25, 1'b0};
		tests[4] = '{4'h7, 32'h0000_FFF8, 8'd5, 3'd2, BURST_INCR, 8'd80, 1'b0};
		tests[5] = '{4'h2, 32'h0000_0800, 8'd2, 3'd2, BURST_INCR, 8'd90, 1'b1};
		tests[6] = '{4'hC, 32'h0000_0900, 8'd4, 3'd1, BURST_INCR, 8'd90, 1'b1};
		tests[7] = '{4'hE, 32'h0000_0A00, 8'd1, 3'd2, BURST_WRAP, 8'd90, 1'b0};
		@(posedge rst_n);
		group_start = 0;
		group_beats = 0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			duty = tests[t].duty;
			send_burst(tests[t]);
			group_beats += int'(tests[t].len) + 1;
			if (!tests[t].chain) begin
				while (r_seen.size() < group_beats) @(posedge clk);
				for (int g = group_start; g <= t; g++) begin
					check_test(g);
				end
				group_start = t + 1;
				group_beats = 0;
			end
		end
		// Wait for the bridge to go idle so a stray beat after the last burst is caught
		@(negedge clk);
		while (!ar_ready || mem_req_valid || r_valid || mem_rsp_valid
			|| mem_pending.size() != 0) begin
			@(negedge clk);
		end
		if (r_seen.size() != 0) begin
			errors++;
			$display("ERROR: %0d R beats arrived that belong to no burst", r_seen.size());
		end
		$display("summary: %0d tests, %0d with errors, %0d checks, %0d errors",
			NUM_TESTS, bad_tests, checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* sim.f */
hdl/axi_rd_pkg.sv
hdl/burst_splitter.sv
hdl/tag_fifo.sv
hdl/read_resp_merger.sv
hdl/axi_rd_bridge.sv
test/tb_clock.sv
test/axi_rd_bridge_properties.sv
test/tb_axi_rd_bridge.sv

/* Makefile */
# Verilator build and run for the AXI read bridge testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_axi_rd_bridge
FILELIST = sim.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
